/* Makefile */
# Verilator build for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dataCacheTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/cacheGolden.txt */
// op_addr_data_mask_word_misses_writebacks, op 0 read 1 write 2 flush 3 invalidate 4 memory
// Memory word at byte address a starts as (a >> 2) ^ c0de0000
0_040_00000000_0_c0de0010_1_0
0_048_00000000_0_c0de0012_0_0
0_04c_00000000_0_c0de0013_0_0
// Masked stores on a hit and on a miss
1_044_11223344_5_00000000_0_0
0_044_00000000_0_c0220044_0_0
1_0a8_aabbccdd_c_00000000_1_0
0_0a8_00000000_0_aabb002a_0_0
// Third tag in set 4 pushes out the dirty line
0_0c0_00000000_0_c0de0030_1_0
0_140_00000000_0_c0de0050_1_1
4_044_00000000_0_c0220044_0_0
4_040_00000000_0_c0de0010_0_0
0_044_00000000_0_c0220044_1_0
// Flush twice
1_14c_01020304_f_00000000_0_0
2_000_00000000_0_00000000_0_2
4_0a8_00000000_0_aabb002a_0_0
4_14c_00000000_0_01020304_0_0
2_000_00000000_0_00000000_0_0
0_14c_00000000_0_01020304_0_0
// Invalidate then refetch
3_000_00000000_0_00000000_0_0
0_0a8_00000000_0_aabb002a_1_0
0_040_00000000_0_c0de0010_1_0
// Back-to-back hits
0_0a0_00000000_0_c0de0028_0_0
0_044_00000000_0_c0220044_0_0
0_0ac_00000000_0_c0de002b_0_0
1_048_deadbeef_f_00000000_0_0
0_048_00000000_0_deadbeef_0_0
0_04c_00000000_0_c0de0013_0_0
// Store merged into a fill, then two dirty evictions
1_1c4_99887766_3_00000000_1_0
0_1c4_00000000_0_c0de7766_0_0
0_240_00000000_0_c0de0090_1_1
4_048_00000000_0_deadbeef_0_0
0_2c4_00000000_0_c0de00b1_1_1
4_1c4_00000000_0_c0de7766_0_0

/* bench/clockGen.sv */
`default_nettype none
//////////////////////////////
// Testbench clock and reset
//////////////////////////////

module clockGen #(
  parameter int period      = 4,
  parameter int resetCycles = 10
) (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Reset leaves on a falling edge, away from the DUT edge
  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
  end

endmodule

`default_nettype wire

/* bench/dataCacheTb.sv */
`default_nettype none
//////////////////////////////
// Data cache testbench
// Golden file driver, line memory model on the bus, checks
//////////////////////////////

module dataCacheTb import cachePkg::*, ctrlPkg::*; ();

  localparam int         numSets      = 8;
  localparam int         maxOps       = 64;
  localparam int         memLineCount = 1 << (paBits - offsetBits);  // Whole address space
  localparam wordT       memKey       = 32'hC0DE0000;                // Word = word address ^ key
  localparam logic [3:0] opRead       = 4'h0;
  localparam logic [3:0] opWrite      = 4'h1;
  localparam logic [3:0] opFlush      = 4'h2;
  localparam logic [3:0] opInval      = 4'h3;
  localparam logic [3:0] opMemCheck   = 4'h4;
  localparam logic [3:0] opEnd        = 4'hF;  // Unused slots

  logic clk, arstN;
  cacheRwT  cacheRw;
  paddrT    pAdr, cacheBusAdr;
  byteMaskT byteMask;
  wordT     cacheWriteData, readDataWord;
  logic     flushCache, invalidateCache, cacheStall, cacheMiss, cacheAccess;
  logic     cacheBusAck = 1'b0;
  lineT     fetchBuffer = '0;
  lineT     cacheBusWriteData;
  busRwT    cacheBusRw;

  logic [91:0] golden [maxOps];     // op, addr, data, mask, word, misses, writebacks
  lineT        memLines [memLineCount];
  logic [31:0] rngState = 32'd15769;
  int busWait = 0;                  // Cycles left before the ack
  int missCount = 0, accessCount = 0, fetchCount = 0, wbCount = 0;
  int valueErrs = 0, eventErrs = 0;
  int opCount = 0, cycleCount = 0, cycleLimit = 0;

  clockGen #(.period(4), .resetCycles(10)) clockGen_i (.clk, .arstN);

  dataCache #(.numSets(numSets)) dut_i (.*);

  //////////////////////////////
  // Helpers
  //////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic wordT memWord(input paddrT a);
    lineT l;
    l = memLines[a[paBits-1:offsetBits]];
    return l[wordBits*a[3:2] +: wordBits];
  endfunction

  task automatic checkWord(input string what, input int idx, input wordT got, input wordT want);
    assert (got == want) else begin
      valueErrs++;
      $display("ERR %0t: op %0d %s word %h, expected %h", $time, idx, what, got, want);
    end
  endtask

  task automatic checkCount(input string what, input int idx, input int got, input int want);
    assert (got == want) else begin
      eventErrs++;
      $display("ERR %0t: op %0d %s count %0d, expected %0d", $time, idx, what, got, want);
    end
  endtask

  // Starts and ends on a falling edge
  task automatic runOp(input int idx, input logic [91:0] entry);
    logic [3:0] op, wantMiss, wantWb;
    paddrT      addr;
    wordT       data, wantWord, gotWord;
    byteMaskT   mask;
    int         missStart, accessStart, fetchStart, wbStart, cycles;
    {op, addr, data, mask, wantWord, wantMiss, wantWb} = entry;
    missStart   = missCount;
    accessStart = accessCount;
    fetchStart  = fetchCount;
    wbStart     = wbCount;
    cycles      = 0;
    gotWord     = '0;
    case (op)
      opRead, opWrite: begin
        cacheRw        = (op == opRead) ? cacheRead : cacheWrite;
        pAdr           = addr;
        byteMask       = mask;
        cacheWriteData = data;
        do begin  // Held until the stall is low at a rising edge
          @(posedge clk);
          cycles++;
          gotWord = readDataWord;
        end while (cacheStall);
        @(negedge clk);
        cacheRw = '0;
      end
      opFlush: begin
        flushCache = 1'b1;
        @(posedge clk);
        @(negedge clk);
        flushCache = 1'b0;
        do @(posedge clk); while (cacheStall);  // Walk over all entries
        @(negedge clk);
      end
      opInval: begin
        invalidateCache = 1'b1;
        @(posedge clk);
        @(negedge clk);
        invalidateCache = 1'b0;
      end
      opMemCheck: checkWord("memory", idx, memWord(addr), wantWord);
      default: begin
        eventErrs++;
        $display("Golden entry %0d has an unknown op code %h", idx, op);
      end
    endcase
    if (op == opRead) checkWord("read", idx, gotWord, wantWord);
    if (op != opMemCheck) begin
      checkCount("miss", idx, missCount - missStart, int'(wantMiss));
      checkCount("fetch", idx, fetchCount - fetchStart, int'(wantMiss));
      checkCount("writeback", idx, wbCount - wbStart, int'(wantWb));
      checkCount("access", idx, accessCount - accessStart, (op <= opWrite) ? 1 : 0);
      if (op <= opWrite && wantMiss == 0) checkCount("stall", idx, cycles - 1, 0);  // Hit
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    cacheRw         = '0;
    pAdr            = '0;
    byteMask        = '0;
    cacheWriteData  = '0;
    flushCache      = 1'b0;
    invalidateCache = 1'b0;
    for (int l = 0; l < memLineCount; l++)
      for (int w = 0; w < wordsPerLine; w++)
        memLines[l][wordBits*w +: wordBits] = wordT'(l * wordsPerLine + w) ^ memKey;
    for (int i = 0; i < maxOps; i++) golden[i] = '1;
    $readmemh("bench/cacheGolden.txt", golden);
    while (opCount < maxOps && golden[opCount][91:88] != opEnd) opCount++;
    cycleLimit = opCount * numSets * numWays * 7 + 200;  // Every op as long as a full flush
    @(posedge arstN);
    @(negedge clk);
    assert (cacheBusRw == '0 && !cacheStall && !cacheMiss && !cacheAccess) else begin
      eventErrs++;
      $display("ERR %0t: outputs not idle after reset", $time);
    end
    for (int i = 0; i < opCount; i++) runOp(i, golden[i]);
    $display("Ran %0d ops with %0d value errors and %0d count errors",
             opCount, valueErrs, eventErrs);
    if (valueErrs == 0 && eventErrs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  //////////////////////////////
  // Bus memory model
  //////////////////////////////
  // Ack comes 1 to 4 cycles after the request is seen
  always @(negedge clk) begin
    if (cacheBusAck) begin
      cacheBusAck = 1'b0;  // One-cycle pulse
      busWait     = 0;
    end else if (cacheBusRw != '0) begin
      if (busWait == 0) begin
        rngState = xorshift(rngState);
        busWait  = 1 + int'(rngState[1:0]);
      end
      busWait = busWait - 1;
      if (busWait == 0) begin
        fetchBuffer = memLines[cacheBusAdr[paBits-1:offsetBits]];
        cacheBusAck = 1'b1;
      end
    end
  end

  // Pulse counts and writeback capture, sampled before the edge
  always @(posedge clk) begin
    if (arstN) begin
      if (cacheMiss) missCount++;
      if (cacheAccess) accessCount++;
      if (cacheBusAck && cacheBusRw == busFetch) fetchCount++;
      if (cacheBusAck && cacheBusRw == busWriteback) begin
        wbCount++;
        memLines[cacheBusAdr[paBits-1:offsetBits]] = cacheBusWriteData;
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles with the golden ops unfinished", cycleLimit);
      $display("Some tests failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* src/cacheFsm.sv */
`default_nettype none
//////////////////////////////
// Cache controller
// Hit service, miss sequence and the flush walk
//////////////////////////////

module cacheFsm import cachePkg::*, ctrlPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  input  cacheRwT cacheRw,
  input  logic    flushCache,       // Pulse in ready
  input  logic    invalidateCache,
  input  logic    cacheBusAck,      // One-cycle done pulse
  output busRwT   cacheBusRw,
  output logic    cacheStall,
  output logic    cacheMiss,
  output logic    cacheAccess,
  output logic    selWriteback,     // Bus address from victim tag
  wayCtrlIf.ctrl  ctrl
);

  cacheStateT state, nextState;
  logic       isRead, isWrite, isReq;
  logic       flushStart;    // Clear the flush counters
  logic       flushAdvance;  // Step to next entry
  logic       flushDone;     // Last set and last way

  assign isRead  = |(cacheRw & cacheRead);
  assign isWrite = |(cacheRw & cacheWrite);
  assign isReq   = isRead | isWrite;

  assign flushDone = ctrl.flushWay[numWays-1] & (&ctrl.flushSet);

  //////////////////////////////
  // State register and flush counters
  //////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state         <= stReady;
      ctrl.flushSet <= '0;
      ctrl.flushWay <= wayT'(1);
    end else begin
      state <= nextState;
      if (flushStart) begin
        ctrl.flushSet <= '0;
        ctrl.flushWay <= wayT'(1);
      end else if (flushAdvance) begin
        ctrl.flushWay <= {ctrl.flushWay[numWays-2:0], ctrl.flushWay[numWays-1]};
        if (ctrl.flushWay[numWays-1]) ctrl.flushSet <= ctrl.flushSet + 1'b1;  // Next set
      end
    end
  end

  //////////////////////////////
  // Next state and outputs
  //////////////////////////////
  always_comb begin
    nextState       = state;
    cacheBusRw      = '0;
    cacheStall      = 1'b1;  // Only ready can release the CPU
    cacheMiss       = 1'b0;
    cacheAccess     = 1'b0;
    selWriteback    = 1'b0;
    ctrl.setValid   = 1'b0;
    ctrl.setDirty   = 1'b0;
    ctrl.clearDirty = 1'b0;
    ctrl.lruWrite   = 1'b0;
    ctrl.selFlush   = 1'b0;
    flushStart      = 1'b0;
    flushAdvance    = 1'b0;

    case (state)
      stReady: begin
        cacheStall = 1'b0;
        if (invalidateCache) begin
          cacheStall = isReq;  // Request retries on the emptied arrays
        end else if (flushCache) begin
          cacheStall = 1'b1;
          flushStart = 1'b1;
          nextState  = stFlushCheck;
        end else if (isReq && ctrl.hit) begin
          cacheAccess   = 1'b1;
          ctrl.lruWrite = 1'b1;
          ctrl.setDirty = isWrite;  // Store commits at this edge
        end else if (isReq) begin
          cacheStall = 1'b1;
          cacheMiss  = 1'b1;
          nextState  = ctrl.lineDirty ? stWriteback : stFetch;
        end
      end

      stWriteback: begin
        selWriteback = 1'b1;
        cacheBusRw   = busWriteback;
        if (cacheBusAck) begin
          ctrl.clearDirty = 1'b1;
          nextState       = stFetch;
        end
      end

      stFetch: begin
        cacheBusRw = busFetch;
        if (cacheBusAck) begin  // Fetch buffer valid only now
          ctrl.setValid = 1'b1;
          ctrl.setDirty = isWrite;  // Store bytes merged into the fill
          nextState     = stWriteLine;
        end
      end

      stWriteLine: begin
        nextState = stReady;  // Fill settles, request retries as a hit
      end

      stFlushCheck: begin
        ctrl.selFlush = 1'b1;
        nextState     = ctrl.lineDirty ? stFlushWriteback : stFlushNext;
      end

      stFlushWriteback: begin
        ctrl.selFlush = 1'b1;
        selWriteback  = 1'b1;
        cacheBusRw    = busWriteback;
        if (cacheBusAck) begin
          ctrl.clearDirty = 1'b1;
          nextState       = stFlushNext;
        end
      end

      stFlushNext: begin
        ctrl.selFlush = 1'b1;
        flushAdvance  = 1'b1;
        nextState     = flushDone ? stReady : stFlushCheck;
      end

      default: nextState = stReady;
    endcase
  end

  // Fetch and writeback are never requested together
  assert property (@(posedge clk) disable iff (!arstN) !(&cacheBusRw));

  // Bus request held until the memory answers
  assert property (@(posedge clk) disable iff (!arstN)
    (|cacheBusRw && !cacheBusAck) |=> $stable(cacheBusRw));

endmodule

`default_nettype wire

/* src/cachePkg.sv */
`default_nettype none
//////////////////////////////
// Cache geometry package
// Fixed sizes and the vector types for addresses, words and lines
//////////////////////////////

package cachePkg;

  //////////////////////////////
  // Geometry
  //////////////////////////////
  localparam int paBits       = 12;  // Physical address width
  localparam int wordBits     = 32;  // CPU word
  localparam int lineBytes    = 16;  // Bytes per line
  localparam int wordsPerLine = 4;
  localparam int numWays      = 2;   // One-bit LRU limits this to two
  localparam int offsetBits   = 4;   // Byte offset inside a line

  // Tag and set widths follow numSets and are derived in each module

  //////////////////////////////
  // Vector types
  //////////////////////////////
  typedef logic [paBits-1:0]       paddrT;     // Physical address
  typedef logic [wordBits-1:0]     wordT;      // One data word
  typedef logic [8*lineBytes-1:0]  lineT;      // One full line
  typedef logic [wordBits/8-1:0]   byteMaskT;  // Byte enables of a word
  typedef logic [lineBytes-1:0]    lineMaskT;  // Byte enables of a line
  typedef logic [numWays-1:0]      wayT;       // One-hot way select

endpackage

`default_nettype wire

/* src/cacheWays.sv */
`default_nettype none
//////////////////////////////
// Two-way cache arrays
// Address decode, tag compare, victim choice and the way state
//////////////////////////////

module cacheWays import cachePkg::*; #(
  parameter int numSets = 8
) (
  input  logic     clk,
  input  logic     arstN,
  input  paddrT    pAdr,
  input  lineT     writeLine,        // Merged store or fill data
  input  lineMaskT lineMask,         // Store byte enables
  input  logic     invalidateCache,
  wayCtrlIf.ways   ctrl
);
  localparam int setBits = $clog2(numSets);
  localparam int tagBits = paBits - setBits - offsetBits;

  // Payload arrays
  logic [tagBits-1:0] tagMem  [numWays][numSets];
  lineT               dataMem [numWays][numSets];

  // Control state
  wayT [numSets-1:0]  validMem;
  wayT [numSets-1:0]  dirtyMem;
  logic [numSets-1:0] lruMem;        // Set means way 1 is least recent

  logic [setBits-1:0] reqSet;
  logic [setBits-1:0] idxSet;        // Request set or flush set
  logic [tagBits-1:0] reqTag;
  logic [tagBits-1:0] wayTag  [numWays];
  lineT               wayLine [numWays];
  wayT                validWay, dirtyWay, hitWay;
  wayT                victimWay, selWay, readWay, writeWay;
  lineMaskT           byteEn;
  logic               cacheHit;

  //////////////////////////////
  // Decode and compare
  //////////////////////////////
  assign reqSet   = pAdr[offsetBits +: setBits];
  assign reqTag   = pAdr[paBits-1 -: tagBits];
  assign idxSet   = ctrl.selFlush ? ctrl.flushSet : reqSet;
  assign validWay = validMem[idxSet];
  assign dirtyWay = dirtyMem[idxSet];

  always_comb begin
    for (int w = 0; w < numWays; w++) begin
      wayTag[w]  = tagMem[w][idxSet];
      wayLine[w] = dataMem[w][idxSet];
      hitWay[w]  = validWay[w] & (wayTag[w] == reqTag);
    end
  end

  assign cacheHit = |hitWay;
  assign ctrl.hit = cacheHit;

  // Empty way wins over the LRU way
  always_comb begin
    if (!validWay[0])      victimWay = 2'b01;
    else if (!validWay[1]) victimWay = 2'b10;
    else                   victimWay = lruMem[idxSet] ? 2'b10 : 2'b01;
  end

  assign selWay  = ctrl.selFlush ? ctrl.flushWay : victimWay;
  assign readWay = (cacheHit && !ctrl.selFlush) ? hitWay : selWay;

  // AND-OR way muxes
  always_comb begin
    ctrl.readLine  = '0;
    ctrl.victimTag = '0;
    for (int w = 0; w < numWays; w++) begin
      if (readWay[w]) ctrl.readLine  = ctrl.readLine | wayLine[w];
      if (selWay[w])  ctrl.victimTag = ctrl.victimTag | wayTag[w];
    end
  end

  assign ctrl.lineDirty = |(selWay & validWay & dirtyWay);

  //////////////////////////////
  // Array writes
  //////////////////////////////
  assign writeWay = ctrl.setValid ? victimWay : hitWay;  // Fill goes to victim
  assign byteEn   = ctrl.setValid ? '1 : lineMask;       // Fill writes all bytes

  always_ff @(posedge clk) begin
    for (int w = 0; w < numWays; w++) begin
      if (writeWay[w] && ctrl.setValid) tagMem[w][reqSet] <= reqTag;
      if (writeWay[w] && (ctrl.setValid || ctrl.setDirty)) begin
        for (int b = 0; b < lineBytes; b++) begin
          if (byteEn[b]) dataMem[w][reqSet][8*b +: 8] <= writeLine[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validMem <= '0;
      dirtyMem <= '0;
      lruMem   <= '0;
    end else begin
      if (invalidateCache) validMem <= '0;  // All sets in one cycle
      else if (ctrl.setValid) validMem[reqSet] <= validMem[reqSet] | victimWay;

      // New line starts clean unless a store rides along
      if (ctrl.setValid)
        dirtyMem[reqSet] <= (dirtyMem[reqSet] & ~victimWay) | (ctrl.setDirty ? victimWay : '0);
      else if (ctrl.setDirty) dirtyMem[reqSet] <= dirtyMem[reqSet] | hitWay;
      else if (ctrl.clearDirty) dirtyMem[idxSet] <= dirtyMem[idxSet] & ~selWay;

      if (ctrl.setValid) lruMem[reqSet] <= victimWay[0];  // Other way is now LRU
      else if (ctrl.lruWrite && cacheHit) lruMem[reqSet] <= hitWay[0];
    end
  end

  // Refills only follow a miss so a tag never sits valid in both ways
  assert property (@(posedge clk) disable iff (!arstN) $onehot0(hitWay));

endmodule

`default_nettype wire

/* src/ctrlPkg.sv */
`default_nettype none
//////////////////////////////
// Cache control package
// Request encodings and controller states
//////////////////////////////

package ctrlPkg;

  // CPU request, [1] read and [0] write
  typedef logic [1:0] cacheRwT;
  localparam cacheRwT cacheRead  = 2'b10;
  localparam cacheRwT cacheWrite = 2'b01;

  // Bus request, [1] line fetch and [0] line writeback
  typedef logic [1:0] busRwT;
  localparam busRwT busFetch     = 2'b10;
  localparam busRwT busWriteback = 2'b01;

  // Controller states
  typedef enum logic [2:0] {
    stReady,           // Serve hits and detect misses
    stWriteback,       // Dirty victim out to memory
    stFetch,           // Line in from memory
    stWriteLine,       // Fill settles and LRU follows
    stFlushCheck,      // Look at one flush entry
    stFlushWriteback,  // Dirty flush entry out
    stFlushNext        // Step the flush counters
  } cacheStateT;

endpackage

`default_nettype wire

/* src/dataCache.sv */
`default_nettype none
//////////////////////////////
// Two-way write-back data cache
// Arrays, controller and result logic
//////////////////////////////

module dataCache import cachePkg::*, ctrlPkg::*; #(
  parameter int numSets = 8
) (
  input  logic     clk,
  input  logic     arstN,
  // CPU side
  input  cacheRwT  cacheRw,            // [1] read, [0] write
  input  paddrT    pAdr,
  input  byteMaskT byteMask,
  input  wordT     cacheWriteData,
  input  logic     flushCache,         // Write back all dirty lines
  input  logic     invalidateCache,    // Drop all lines
  output logic     cacheStall,
  output wordT     readDataWord,
  output logic     cacheMiss,          // Counter pulses
  output logic     cacheAccess,
  // Bus side
  input  logic     cacheBusAck,
  input  lineT     fetchBuffer,
  output busRwT    cacheBusRw,         // [1] fetch, [0] writeback
  output paddrT    cacheBusAdr,
  output lineT     cacheBusWriteData
);

  lineT     writeLine;
  lineMaskT lineMask;
  byteMaskT storeMask;     // Byte mask of stores only
  logic     selWriteback;

  wayCtrlIf #(.numSets(numSets)) wayBus ();

  // Loads must not merge bytes into a fill
  assign storeMask = (|(cacheRw & cacheWrite)) ? byteMask : '0;

  cacheWays #(.numSets(numSets)) u_ways (
    .clk, .arstN, .pAdr, .writeLine, .lineMask, .invalidateCache,
    .ctrl (wayBus.ways)
  );

  cacheFsm u_fsm (
    .clk, .arstN, .cacheRw, .flushCache, .invalidateCache, .cacheBusAck,
    .cacheBusRw, .cacheStall, .cacheMiss, .cacheAccess, .selWriteback,
    .ctrl (wayBus.ctrl)
  );

  lineSelect #(.numSets(numSets)) u_select (
    .pAdr, .byteMask (storeMask), .cacheWriteData, .fetchBuffer, .selWriteback,
    .ctrl (wayBus.data),
    .readDataWord, .writeLine, .lineMask, .cacheBusAdr, .cacheBusWriteData
  );

endmodule

`default_nettype wire

/* src/lineSelect.sv */
`default_nettype none
//////////////////////////////
// Cache result logic
// Load word select, store merge and bus address
//////////////////////////////

module lineSelect import cachePkg::*; #(
  parameter int numSets = 8
) (
  input  paddrT    pAdr,
  input  byteMaskT byteMask,          // Zero for loads
  input  wordT     cacheWriteData,
  input  lineT     fetchBuffer,       // Line from the bus
  input  logic     selWriteback,
  wayCtrlIf.data   ctrl,
  output wordT     readDataWord,
  output lineT     writeLine,
  output lineMaskT lineMask,
  output paddrT    cacheBusAdr,
  output lineT     cacheBusWriteData
);
  localparam int setBits   = $clog2(numSets);
  localparam int wordSel   = $clog2(wordsPerLine);
  localparam int wordBytes = wordBits / 8;

  logic [wordSel-1:0] wordIdx;   // Word within the line
  logic [setBits-1:0] reqSet;
  lineT               storeLine; // Store word copied to every slot

  assign wordIdx = pAdr[offsetBits-1 -: wordSel];
  assign reqSet  = pAdr[offsetBits +: setBits];

  //////////////////////////////
  // Read path
  //////////////////////////////
  assign readDataWord = ctrl.readLine[wordIdx*wordBits +: wordBits];

  //////////////////////////////
  // Write path
  //////////////////////////////
  // Word byte mask moved to its place in the line
  assign lineMask  = lineMaskT'(byteMask) << (wordIdx * wordBytes);
  assign storeLine = {wordsPerLine{cacheWriteData}};

  // Store bytes over the fetched line
  // A hit writes only the masked bytes so the rest does not matter
  always_comb begin
    for (int b = 0; b < lineBytes; b++) begin
      writeLine[8*b +: 8] = lineMask[b] ? storeLine[8*b +: 8] : fetchBuffer[8*b +: 8];
    end
  end

  //////////////////////////////
  // Bus side
  //////////////////////////////
  always_comb begin
    if (ctrl.selFlush)
      cacheBusAdr = {ctrl.victimTag, ctrl.flushSet, {offsetBits{1'b0}}};  // Flush entry
    else if (selWriteback)
      cacheBusAdr = {ctrl.victimTag, reqSet, {offsetBits{1'b0}}};        // Evicted line
    else
      cacheBusAdr = {pAdr[paBits-1:offsetBits], {offsetBits{1'b0}}};    // Line fetch
  end

  assign cacheBusWriteData = ctrl.readLine;  // Selected way during writeback

endmodule

`default_nettype wire

/* src/wayCtrlIf.sv */
`default_nettype none
//////////////////////////////
// Controller to way array link
// Array update strobes, flush index and the array status back
//////////////////////////////

interface wayCtrlIf import cachePkg::*; #(
  parameter int numSets = 8
);
  localparam int setBits = $clog2(numSets);
  localparam int tagBits = paBits - setBits - offsetBits;

  // Controller to arrays
  logic               setValid;    // Fill line, set valid, write tag
  logic               setDirty;    // Store bytes and mark dirty
  logic               clearDirty;  // After a writeback
  logic               lruWrite;    // Touch the hit way
  logic               selFlush;    // Index by the flush counters
  logic [setBits-1:0] flushSet;
  wayT                flushWay;    // One-hot

  // Arrays to controller and result logic
  logic               hit;
  logic               lineDirty;   // Selected way valid and dirty
  logic [tagBits-1:0] victimTag;
  lineT               readLine;

  modport ctrl (
    output setValid, setDirty, clearDirty, lruWrite, selFlush, flushSet, flushWay,
    input  hit, lineDirty
  );

  modport ways (
    input  setValid, setDirty, clearDirty, lruWrite, selFlush, flushSet, flushWay,
    output hit, lineDirty, victimTag, readLine
  );

  modport data (input readLine, victimTag, selFlush, flushSet);

endinterface

`default_nettype wire

/* vlog.f */
src/cachePkg.sv
src/ctrlPkg.sv
src/wayCtrlIf.sv
src/cacheWays.sv
src/cacheFsm.sv
src/lineSelect.sv
src/dataCache.sv
bench/clockGen.sv
bench/dataCacheTb.sv
